// ==== Makefile ====
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -j 0 --top-module tb_idma_stream -f verilog.f -o Vtb

run: compile
	./obj_dir/Vtb > sim.log 2>&1 || true
	cat sim.log
	grep -q "Result: PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== idma_axi_stream_read.sv ====
// Stream read datapath that masks and realigns source beats into the byte buffer
`default_nettype none

module idma_axi_stream_read import idma_stream_pkg::*; (
    // Read datapath request
    input  r_dp_req_t   r_dp_req_i,
    input  logic        r_dp_req_valid_i,
    output logic        r_dp_req_ready_o,
    // Read datapath response
    output dp_rsp_t     r_dp_rsp_o,
    output logic        r_dp_rsp_valid_o,
    input  logic        r_dp_rsp_ready_i,
    // Source stream
    output stream_rsp_t read_req_o,
    input  stream_req_t read_rsp_i,
    // Byte buffer push side
    output beat_t       buffer_in_o,
    output strb_t       buffer_in_valid_o,
    input  strb_t       buffer_in_ready_i
);
    localparam int unsigned W = $bits(strb_t);

    // Source-aligned lanes holding payload
    strb_t read_mask;
    // Same lanes after rotation into destination alignment
    strb_t mask_in;
    logic [2*W-1:0]   mask_dbl;
    logic [16*W-1:0]  data_dbl;
    logic             in_ready;
    logic             take;

    // ----------------------------------------------------------------------
    // Mask of valid source lanes
    // ----------------------------------------------------------------------
    // First beat drops lanes below offset, last beat drops lanes from tailer on
    assign read_mask = ('1 << r_dp_req_i.offset) &
        ((r_dp_req_i.tailer != '0) ? ('1 >> (W - r_dp_req_i.tailer)) : '1);

    // ----------------------------------------------------------------------
    // Rotation into destination lanes
    // ----------------------------------------------------------------------
    // Doubled vector shifted left, upper half is the rotated copy
    assign mask_dbl    = {read_mask, read_mask} << r_dp_req_i.shift;
    assign mask_in     = mask_dbl[2*W-1 -: W];
    assign data_dbl    = {read_rsp_i.tdata, read_rsp_i.tdata} << {r_dp_req_i.shift, 3'b000};
    assign buffer_in_o = data_dbl[16*W-1 -: 8*W];

    // ----------------------------------------------------------------------
    // Handshakes
    // ----------------------------------------------------------------------
    // Every lane touched by this beat must have room
    assign in_ready = &(buffer_in_ready_i | ~mask_in);

    // Ready towards the source never looks at tvalid
    assign read_req_o.tready = r_dp_req_valid_i & in_ready & r_dp_rsp_ready_i;
    assign take              = read_req_o.tready & read_rsp_i.tvalid;

    assign buffer_in_valid_o = take ? mask_in : '0;

    // One beat completes one request and yields one response
    assign r_dp_req_ready_o = take;
    assign r_dp_rsp_valid_o = take;

    // No error path on a stream source
    assign r_dp_rsp_o.resp  = '0;
    assign r_dp_rsp_o.first = 1'b1;
    assign r_dp_rsp_o.last  = 1'b1;

endmodule

`default_nettype wire

// ==== idma_byte_buffer.sv ====
// Realignment buffer with one small FIFO per byte lane, used between read and write datapaths
`include "idma_stream_cfg.svh"
`default_nettype none

module idma_byte_buffer import idma_stream_pkg::*; (
    input  logic  clk_i,
    input  logic  rst_n_i,
    input  beat_t data_i,
    input  strb_t push_i,
    input  strb_t pop_i,
    output strb_t ready_o,
    output beat_t data_o,
    output strb_t valid_o
);
    localparam int unsigned W     = $bits(strb_t);
    localparam int unsigned DEPTH = `IDMA_BUF_DEPTH;
    localparam int unsigned PW    = $clog2(DEPTH);

    // ----------------------------------------------------------------------
    // Independent lane FIFOs
    // ----------------------------------------------------------------------
    for (genvar l = 0; l < W; l++) begin : gen_lane
        byte_t          mem [DEPTH];
        logic [PW-1:0]  wr_ptr_q;
        logic [PW-1:0]  rd_ptr_q;
        fill_t          fill_q;
        logic           push;
        logic           pop;

        // Status straight from the fill count
        assign ready_o[l] = (fill_q != fill_t'(DEPTH));
        assign valid_o[l] = (fill_q != '0);
        // Head entry is always on the output
        assign data_o[l]  = mem[rd_ptr_q];

        assign push = push_i[l] & ready_o[l];
        assign pop  = pop_i[l] & valid_o[l];

        always_ff @(posedge clk_i) begin
            if (!rst_n_i) begin
                wr_ptr_q <= '0;
                rd_ptr_q <= '0;
                fill_q   <= '0;
            end else begin
                if (push) begin
                    wr_ptr_q <= (wr_ptr_q == PW'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
                end
                if (pop) begin
                    rd_ptr_q <= (rd_ptr_q == PW'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
                end
                // Push and pop in one cycle leave the count alone
                fill_q <= fill_q + fill_t'(push) - fill_t'(pop);
            end
        end

        // Storage only written on an accepted push
        always_ff @(posedge clk_i) begin
            if (push) begin
                mem[wr_ptr_q] <= data_i[l];
            end
        end
    end

endmodule

`default_nettype wire

// ==== idma_stream_cfg.svh ====
// Build-time sizes of the stream transport layer, included by the package and the testbench
`ifndef IDMA_STREAM_CFG_SVH
`define IDMA_STREAM_CFG_SVH

// ----------------------------------------------------------------------
// Datapath geometry
// ----------------------------------------------------------------------

// Bytes per stream beat
`define IDMA_STRB_WIDTH 4

// Entries in each byte-lane FIFO of the realignment buffer
`define IDMA_BUF_DEPTH 2

// ----------------------------------------------------------------------
// Descriptor sizing
// ----------------------------------------------------------------------

// Bits in the transfer length field
`define IDMA_LEN_WIDTH 8

`endif

// ==== idma_stream_ctrl.sv ====
// Transfer control FSM that splits one descriptor into per-beat read and write requests
`default_nettype none

module idma_stream_ctrl import idma_stream_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_n_i,
    input  desc_t     desc_i,
    input  logic      desc_valid_i,
    output logic      desc_ready_o,
    output logic      done_o,
    output r_dp_req_t r_dp_req_o,
    output logic      r_dp_req_valid_o,
    input  logic      r_dp_req_ready_i,
    input  dp_rsp_t   r_dp_rsp_i,
    input  logic      r_dp_rsp_valid_i,
    output logic      r_dp_rsp_ready_o,
    output w_dp_req_t w_dp_req_o,
    output logic      w_dp_req_valid_o,
    input  logic      w_dp_req_ready_i,
    input  dp_rsp_t   w_dp_rsp_i,
    input  logic      w_dp_rsp_valid_i,
    output logic      w_dp_rsp_ready_o
);
    localparam int unsigned W  = $bits(strb_t);
    localparam int unsigned OW = $bits(offset_t);
    localparam int unsigned LW = $bits(len_t);

    ctrl_state_e state_q;
    desc_t       desc_q;
    // Requests still to issue and responses still to collect
    len_t        r_left_q, w_left_q, r_rsp_left_q, w_rsp_left_q;
    len_t        r_left_d, w_left_d, r_rsp_left_d, w_rsp_left_d;
    logic        r_first_q, w_first_q;
    logic [LW:0] src_end, dst_end;
    len_t        src_beats, dst_beats;
    offset_t     src_tail, dst_tail;
    logic        r_hs, w_hs, r_rsp_hs, w_rsp_hs;

    // ----------------------------------------------------------------------
    // Beat counts from the incoming descriptor
    // ----------------------------------------------------------------------
    assign src_end   = desc_i.length + desc_i.src_offset;
    assign dst_end   = desc_i.length + desc_i.dst_offset;
    assign src_beats = len_t'((src_end + (W - 1)) >> OW);
    assign dst_beats = len_t'((dst_end + (W - 1)) >> OW);

    // Lane after the final byte, zero for a full last beat
    assign src_tail = offset_t'(desc_q.length + desc_q.src_offset);
    assign dst_tail = offset_t'(desc_q.length + desc_q.dst_offset);

    assign desc_ready_o     = (state_q == IDLE);
    assign r_dp_rsp_ready_o = 1'b1;
    assign w_dp_rsp_ready_o = (state_q != IDLE);

    // ----------------------------------------------------------------------
    // Request generation
    // ----------------------------------------------------------------------
    assign r_dp_req_valid_o  = (state_q == RUN) && (r_left_q != '0);
    assign r_dp_req_o.offset = r_first_q ? desc_q.src_offset : '0;
    assign r_dp_req_o.tailer = (r_left_q == len_t'(1)) ? src_tail : '0;
    assign r_dp_req_o.shift  = desc_q.dst_offset - desc_q.src_offset;

    assign w_dp_req_valid_o  = (state_q == RUN) && (w_left_q != '0);
    assign w_dp_req_o.offset = w_first_q ? desc_q.dst_offset : '0;
    assign w_dp_req_o.tailer = (w_left_q == len_t'(1)) ? dst_tail : '0;
    assign w_dp_req_o.last   = (w_left_q == len_t'(1));

    assign r_hs     = r_dp_req_valid_o & r_dp_req_ready_i;
    assign w_hs     = w_dp_req_valid_o & w_dp_req_ready_i;
    assign r_rsp_hs = r_dp_rsp_valid_i & r_dp_rsp_ready_o & r_dp_rsp_i.last;
    assign w_rsp_hs = w_dp_rsp_valid_i & w_dp_rsp_ready_o & w_dp_rsp_i.last;

    assign r_left_d     = r_left_q - len_t'(r_hs);
    assign w_left_d     = w_left_q - len_t'(w_hs);
    assign r_rsp_left_d = r_rsp_left_q - len_t'(r_rsp_hs);
    assign w_rsp_left_d = w_rsp_left_q - len_t'(w_rsp_hs);

    // Descriptor fields held for the whole transfer
    always_ff @(posedge clk_i) begin
        if (desc_valid_i && desc_ready_o) begin
            desc_q <= desc_i;
        end
    end

    // ----------------------------------------------------------------------
    // Transfer FSM
    // ----------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q      <= IDLE;
            done_o       <= 1'b0;
            r_left_q     <= '0;
            w_left_q     <= '0;
            r_rsp_left_q <= '0;
            w_rsp_left_q <= '0;
            r_first_q    <= 1'b0;
            w_first_q    <= 1'b0;
        end else begin
            done_o <= 1'b0;
            if (state_q == IDLE) begin
                if (desc_valid_i) begin
                    r_left_q     <= src_beats;
                    w_left_q     <= dst_beats;
                    r_rsp_left_q <= src_beats;
                    w_rsp_left_q <= dst_beats;
                    r_first_q    <= 1'b1;
                    w_first_q    <= 1'b1;
                    state_q      <= RUN;
                end
            end else begin
                r_left_q     <= r_left_d;
                w_left_q     <= w_left_d;
                r_rsp_left_q <= r_rsp_left_d;
                w_rsp_left_q <= w_rsp_left_d;
                if (r_hs) r_first_q <= 1'b0;
                if (w_hs) w_first_q <= 1'b0;
                // Last response closes the transfer
                if (r_rsp_left_d == '0 && w_rsp_left_d == '0) begin
                    state_q <= IDLE;
                    done_o  <= 1'b1;
                end else if (r_left_d == '0 && w_left_d == '0) begin
                    state_q <= DRAIN;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== idma_stream_pkg.sv ====
// Shared types of the stream transport layer, imported by every datapath and control module
`include "idma_stream_cfg.svh"
`default_nettype none

package idma_stream_pkg;

    // Widths that carry a meaning
    typedef logic [7:0]                                byte_t;
    typedef logic [`IDMA_STRB_WIDTH-1:0]               strb_t;
    typedef logic [$clog2(`IDMA_STRB_WIDTH)-1:0]       offset_t;
    typedef logic [`IDMA_LEN_WIDTH-1:0]                len_t;
    typedef byte_t [`IDMA_STRB_WIDTH-1:0]              beat_t;
    // Per-lane occupancy of the byte buffer, counts up to the full depth
    typedef logic [$clog2(`IDMA_BUF_DEPTH+1)-1:0]      fill_t;

    // ----------------------------------------------------------------------
    // Transfer descriptor and datapath bundles
    // ----------------------------------------------------------------------
    typedef struct packed {
        len_t    length;
        offset_t src_offset;
        offset_t dst_offset;
    } desc_t;

    // Shift rotates source lanes into destination lanes
    typedef struct packed {
        offset_t offset;
        offset_t tailer;
        offset_t shift;
    } r_dp_req_t;

    typedef struct packed {
        offset_t offset;
        offset_t tailer;
        logic    last;
    } w_dp_req_t;

    typedef struct packed {
        logic [1:0] resp;
        logic       first;
        logic       last;
    } dp_rsp_t;

    // ----------------------------------------------------------------------
    // Stream channels
    // ----------------------------------------------------------------------
    typedef struct packed {
        beat_t tdata;
        strb_t tstrb;
        logic  tvalid;
        logic  tlast;
    } stream_req_t;

    typedef struct packed {
        logic tready;
    } stream_rsp_t;

    // Control FSM states
    typedef enum logic [1:0] {
        IDLE,
        RUN,
        DRAIN
    } ctrl_state_e;

endpackage

`default_nettype wire

// ==== idma_stream_top.sv ====
// Top level of the stream transport layer, connecting control and datapath to the two streams
`default_nettype none

module idma_stream_top import idma_stream_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_n_i,
    // Descriptor port
    input  desc_t       desc_i,
    input  logic        desc_valid_i,
    output logic        desc_ready_o,
    output logic        done_o,
    // Source stream
    input  stream_req_t src_req_i,
    output stream_rsp_t src_rsp_o,
    // Destination stream
    output stream_req_t dst_req_o,
    input  stream_rsp_t dst_rsp_i
);
    // ----------------------------------------------------------------------
    // Internal datapath links
    // ----------------------------------------------------------------------
    r_dp_req_t r_dp_req;
    logic      r_dp_req_valid, r_dp_req_ready;
    dp_rsp_t   r_dp_rsp;
    logic      r_dp_rsp_valid, r_dp_rsp_ready;
    w_dp_req_t w_dp_req;
    logic      w_dp_req_valid, w_dp_req_ready;
    dp_rsp_t   w_dp_rsp;
    logic      w_dp_rsp_valid, w_dp_rsp_ready;
    // Buffer push and pop sides
    beat_t     buf_in_data, buf_out_data;
    strb_t     buf_push, buf_ready, buf_valid, buf_pop;

    idma_stream_ctrl i_ctrl (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .desc_i           (desc_i),
        .desc_valid_i     (desc_valid_i),
        .desc_ready_o     (desc_ready_o),
        .done_o           (done_o),
        .r_dp_req_o       (r_dp_req),
        .r_dp_req_valid_o (r_dp_req_valid),
        .r_dp_req_ready_i (r_dp_req_ready),
        .r_dp_rsp_i       (r_dp_rsp),
        .r_dp_rsp_valid_i (r_dp_rsp_valid),
        .r_dp_rsp_ready_o (r_dp_rsp_ready),
        .w_dp_req_o       (w_dp_req),
        .w_dp_req_valid_o (w_dp_req_valid),
        .w_dp_req_ready_i (w_dp_req_ready),
        .w_dp_rsp_i       (w_dp_rsp),
        .w_dp_rsp_valid_i (w_dp_rsp_valid),
        .w_dp_rsp_ready_o (w_dp_rsp_ready)
    );

    idma_axi_stream_read i_read (
        .r_dp_req_i        (r_dp_req),
        .r_dp_req_valid_i  (r_dp_req_valid),
        .r_dp_req_ready_o  (r_dp_req_ready),
        .r_dp_rsp_o        (r_dp_rsp),
        .r_dp_rsp_valid_o  (r_dp_rsp_valid),
        .r_dp_rsp_ready_i  (r_dp_rsp_ready),
        .read_req_o        (src_rsp_o),
        .read_rsp_i        (src_req_i),
        .buffer_in_o       (buf_in_data),
        .buffer_in_valid_o (buf_push),
        .buffer_in_ready_i (buf_ready)
    );

    idma_byte_buffer i_buffer (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .data_i  (buf_in_data),
        .push_i  (buf_push),
        .pop_i   (buf_pop),
        .ready_o (buf_ready),
        .data_o  (buf_out_data),
        .valid_o (buf_valid)
    );

    idma_stream_write i_write (
        .w_dp_req_i         (w_dp_req),
        .w_dp_req_valid_i   (w_dp_req_valid),
        .w_dp_req_ready_o   (w_dp_req_ready),
        .w_dp_rsp_o         (w_dp_rsp),
        .w_dp_rsp_valid_o   (w_dp_rsp_valid),
        .w_dp_rsp_ready_i   (w_dp_rsp_ready),
        .buffer_out_i       (buf_out_data),
        .buffer_out_valid_i (buf_valid),
        .buffer_out_pop_o   (buf_pop),
        .write_req_o        (dst_req_o),
        .write_rsp_i        (dst_rsp_i)
    );

endmodule

`default_nettype wire

// ==== idma_stream_write.sv ====
// Stream write datapath that drains whole destination beats from the byte buffer
`default_nettype none

module idma_stream_write import idma_stream_pkg::*; (
    // Write datapath request
    input  w_dp_req_t   w_dp_req_i,
    input  logic        w_dp_req_valid_i,
    output logic        w_dp_req_ready_o,
    // Write datapath response
    output dp_rsp_t     w_dp_rsp_o,
    output logic        w_dp_rsp_valid_o,
    input  logic        w_dp_rsp_ready_i,
    // Byte buffer pop side
    input  beat_t       buffer_out_i,
    input  strb_t       buffer_out_valid_i,
    output strb_t       buffer_out_pop_o,
    // Destination stream
    output stream_req_t write_req_o,
    input  stream_rsp_t write_rsp_i
);
    localparam int unsigned W = $bits(strb_t);

    strb_t write_mask;
    logic  out_valid;
    logic  hs;

    // ----------------------------------------------------------------------
    // Destination lane mask
    // ----------------------------------------------------------------------
    assign write_mask = ('1 << w_dp_req_i.offset) &
        ((w_dp_req_i.tailer != '0) ? ('1 >> (W - w_dp_req_i.tailer)) : '1);

    // Beat is complete once every strobed lane holds a byte
    assign out_valid = &(buffer_out_valid_i | ~write_mask);

    // ----------------------------------------------------------------------
    // Destination beat
    // ----------------------------------------------------------------------
    assign write_req_o.tvalid = w_dp_req_valid_i & out_valid & w_dp_rsp_ready_i;
    assign write_req_o.tstrb  = write_mask;
    assign write_req_o.tlast  = w_dp_req_i.last;

    // Unstrobed lanes carry zero
    always_comb begin
        for (int l = 0; l < W; l++) begin
            write_req_o.tdata[l] = write_mask[l] ? buffer_out_i[l] : '0;
        end
    end

    // ----------------------------------------------------------------------
    // Completion
    // ----------------------------------------------------------------------
    assign hs = write_req_o.tvalid & write_rsp_i.tready;

    // Pop only the lanes that left in this beat
    assign buffer_out_pop_o = hs ? write_mask : '0;
    assign w_dp_req_ready_o = hs;
    assign w_dp_rsp_valid_o = hs;

    assign w_dp_rsp_o.resp  = '0;
    assign w_dp_rsp_o.first = 1'b1;
    assign w_dp_rsp_o.last  = 1'b1;

endmodule

`default_nettype wire

// ==== tb_clk_gen.sv ====
// Free-running testbench clock with a period of 4 time units, instantiated by the testbench top
`default_nettype none

module tb_clk_gen (
    output logic clk_o
);
    // Toggle every half period, starting low
    initial begin
        clk_o = 1'b0;
        forever begin
            #2 clk_o = ~clk_o;
        end
    end

endmodule

`default_nettype wire

// ==== tb_idma_stream.sv ====
// Table-driven testbench for the stream transport top, run as the simulation top module
`include "idma_stream_cfg.svh"
`default_nettype none

module tb_idma_stream import idma_stream_pkg::*; ();

    // One row of the stimulus table with its hand-derived expectations
    typedef struct packed {
        len_t    length;
        offset_t src_off;
        offset_t dst_off;
        logic    src_stall;
        logic    dst_bp;
        len_t    beats;
        strb_t   first_strb;
        strb_t   last_strb;
    } test_t;

    localparam int NUM_TESTS = 8;

    // length, src, dst, src stall, dst back-pressure, dst beats, first tstrb, last tstrb
    test_t tests [NUM_TESTS] = '{
        '{8'd16, 2'd0, 2'd0, 1'b0, 1'b0, 8'd4,  4'hF, 4'hF},
        '{8'd13, 2'd3, 2'd1, 1'b0, 1'b0, 8'd4,  4'hE, 4'h3},
        '{8'd7,  2'd1, 2'd3, 1'b0, 1'b0, 8'd3,  4'h8, 4'h3},
        '{8'd32, 2'd2, 2'd0, 1'b1, 1'b1, 8'd8,  4'hF, 4'hF},
        '{8'd21, 2'd0, 2'd3, 1'b1, 1'b0, 8'd6,  4'h8, 4'hF},
        '{8'd9,  2'd3, 2'd2, 1'b0, 1'b1, 8'd3,  4'hC, 4'h7},
        '{8'd1,  2'd2, 2'd2, 1'b1, 1'b1, 8'd1,  4'h4, 4'h4},
        '{8'd40, 2'd1, 2'd3, 1'b1, 1'b1, 8'd11, 4'h8, 4'h7}
    };

    logic        clk;
    logic        rst_n;
    desc_t       desc;
    logic        desc_valid;
    logic        desc_ready;
    logic        done;
    stream_req_t src_req;
    stream_rsp_t src_rsp;
    stream_req_t dst_req;
    stream_rsp_t dst_rsp;

    // Data bytes of the running transfer, in source order
    byte_t       src_bytes [$];
    byte_t       exp_bytes [$];
    integer      seed;
    integer      src_seed;
    integer      dst_seed;
    int          cycles;
    int          cycle_limit;
    int          done_count;

    tb_clk_gen i_clk_gen (
        .clk_o (clk)
    );

    idma_stream_top DUT (
        .clk_i        (clk),
        .rst_n_i      (rst_n),
        .desc_i       (desc),
        .desc_valid_i (desc_valid),
        .desc_ready_o (desc_ready),
        .done_o       (done),
        .src_req_i    (src_req),
        .src_rsp_o    (src_rsp),
        .dst_req_o    (dst_req),
        .dst_rsp_i    (dst_rsp)
    );

    // ----------------------------------------------------------------------
    // Failure reporting
    // ----------------------------------------------------------------------
    task automatic report_failure(input string reason);
        $display("%s", reason);
        $display("Result: FAILED");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error: %s is 0x%0h, expected 0x%0h", name, got, exp);
            report_failure("DUT output does not match the expected value");
        end
    endtask

    // Cycle budget scales with the bytes moved by the whole table
    function automatic int timeout_limit();
        int sum;
        sum = 0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            sum += 8 * (int'(tests[t].length) + 8);
        end
        return sum;
    endfunction

    // ----------------------------------------------------------------------
    // Monitors
    // ----------------------------------------------------------------------
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            report_failure($sformatf("Timeout after %0d cycles, a transfer never finished",
                                     cycles));
        end
    end

    // Pre-edge value of done, one count per pulse cycle
    always @(posedge clk) begin
        if (done) begin
            done_count <= done_count + 1;
        end
    end

    // ----------------------------------------------------------------------
    // Source stream model
    // ----------------------------------------------------------------------
    task automatic drive_source(input test_t tc);
        int     nbeats;
        int     k;
        int     pos;
        integer rnd;
        beat_t  beat;
        nbeats = (int'(tc.src_off) + int'(tc.length) + `IDMA_STRB_WIDTH - 1)
                 / `IDMA_STRB_WIDTH;
        k = 0;
        while (k < nbeats) begin
            // Lanes outside the payload carry filler
            for (int l = 0; l < `IDMA_STRB_WIDTH; l++) begin
                pos = k * `IDMA_STRB_WIDTH + l - int'(tc.src_off);
                if (pos >= 0 && pos < int'(tc.length)) begin
                    beat[l] = src_bytes[pos];
                end else begin
                    rnd = $random(src_seed);
                    beat[l] = rnd[7:0];
                end
            end
            @(negedge clk);
            rnd = $random(src_seed);
            src_req.tvalid = !tc.src_stall || rnd[0];
            src_req.tdata  = beat;
            // Sample mid low phase, before the next rising edge
            #1;
            if (src_req.tvalid && src_rsp.tready) begin
                k++;
            end
        end
        @(negedge clk);
        src_req.tvalid = 1'b0;
    endtask

    // ----------------------------------------------------------------------
    // Destination sink and checker
    // ----------------------------------------------------------------------
    task automatic sink_beats(input test_t tc, input int idx);
        int     beat_idx;
        logic   got_last;
        integer rnd;
        strb_t  exp_strb;
        byte_t  exp_byte;
        beat_idx = 0;
        got_last = 1'b0;
        while (!got_last) begin
            @(negedge clk);
            rnd = $random(dst_seed);
            dst_rsp.tready = !tc.dst_bp || rnd[0];
            #1;
            if (dst_req.tvalid && dst_rsp.tready) begin
                if (beat_idx == 0) begin
                    exp_strb = tc.first_strb;
                end else if (beat_idx == int'(tc.beats) - 1) begin
                    exp_strb = tc.last_strb;
                end else begin
                    exp_strb = '1;
                end
                check_value("dst tstrb", 32'(dst_req.tstrb), 32'(exp_strb));
                check_value("dst tlast", 32'(dst_req.tlast),
                            32'(beat_idx == int'(tc.beats) - 1));
                check_value("desc_ready_o", 32'(desc_ready), 32'd0);
                // No done pulse before the tlast handshake
                check_value("done count", done_count, idx);
                for (int l = 0; l < `IDMA_STRB_WIDTH; l++) begin
                    if (dst_req.tstrb[l]) begin
                        if (exp_bytes.size() == 0) begin
                            report_failure("Destination delivered more bytes than were sent");
                        end
                        exp_byte = exp_bytes.pop_front();
                        check_value("dst tdata byte", 32'(dst_req.tdata[l]), 32'(exp_byte));
                    end else begin
                        check_value("dst tdata idle lane", 32'(dst_req.tdata[l]), 32'd0);
                    end
                end
                beat_idx++;
                got_last = dst_req.tlast;
            end
        end
        @(negedge clk);
        dst_rsp.tready = 1'b0;
    endtask

    // ----------------------------------------------------------------------
    // One descriptor from the table
    // ----------------------------------------------------------------------
    task automatic run_test(input test_t tc, input int idx);
        integer rnd;
        src_bytes.delete();
        for (int i = 0; i < int'(tc.length); i++) begin
            rnd = $random(seed);
            src_bytes.push_back(rnd[7:0]);
            exp_bytes.push_back(rnd[7:0]);
        end
        @(negedge clk);
        check_value("desc_ready_o", 32'(desc_ready), 32'd1);
        desc.length     = tc.length;
        desc.src_offset = tc.src_off;
        desc.dst_offset = tc.dst_off;
        desc_valid      = 1'b1;
        @(negedge clk);
        desc_valid = 1'b0;
        check_value("desc_ready_o", 32'(desc_ready), 32'd0);
        fork
            drive_source(tc);
            sink_beats(tc, idx);
        join
        while (done_count == idx) begin
            @(negedge clk);
        end
        // Pulse must be a single cycle
        repeat (2) @(negedge clk);
        check_value("done count", done_count, idx + 1);
        check_value("done_o", 32'(done), 32'd0);
        check_value("desc_ready_o", 32'(desc_ready), 32'd1);
    endtask

    // ----------------------------------------------------------------------
    // Main sequence
    // ----------------------------------------------------------------------
    initial begin
        seed        = 75;
        src_seed    = seed + 1;
        dst_seed    = seed + 2;
        cycles      = 0;
        done_count  = 0;
        cycle_limit = timeout_limit();
        desc        = '0;
        desc_valid  = 1'b0;
        src_req     = '0;
        dst_rsp     = '0;
        rst_n       = 1'b0;
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        #1;
        // Idle state straight out of reset
        check_value("dst tvalid", 32'(dst_req.tvalid), 32'd0);
        check_value("src tready", 32'(src_rsp.tready), 32'd0);
        check_value("done_o", 32'(done), 32'd0);
        check_value("desc_ready_o", 32'(desc_ready), 32'd1);
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_test(tests[t], t);
        end
        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+.
idma_stream_pkg.sv
idma_axi_stream_read.sv
idma_byte_buffer.sv
idma_stream_write.sv
idma_stream_ctrl.sv
idma_stream_top.sv
tb_clk_gen.sv
tb_idma_stream.sv
